// File: src/can_pkg.sv
package can_pkg;

	//======================================================================
	// Field lengths, in bits after destuffing
	//======================================================================

	parameter int unsigned ID_A_BITS = 11;          // Base identifier
	parameter int unsigned ID_B_BITS = 18;          // Identifier extension
	parameter int unsigned DLC_BITS = 4;
	parameter int unsigned CRC_BITS = 15;
	parameter int unsigned EOF_BITS = 7;            // Recessive end of frame
	parameter int unsigned STUFF_RUN = 5;           // Equal bits before a stuff bit
	parameter int unsigned IDLE_RECOVERY_BITS = 11; // Recessive run that frees the bus
	parameter int unsigned MAX_DATA_BYTES = 8;

	//======================================================================
	// Frame types
	//======================================================================

	typedef logic [28:0] can_id_t;  // Base id right-aligned
	typedef logic [3:0]  can_dlc_t;
	typedef logic [63:0] can_data_t; // First byte is the top used byte
	typedef logic [CRC_BITS-1:0] can_crc_t;

	// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	parameter can_crc_t CRC15_POLY = 15'h4599;

	typedef struct packed
	{
		logic      ide;  // 1 for extended format
		logic      rtr;  // 1 for remote frame
		can_id_t   id;
		can_dlc_t  dlc;  // Already capped at 8
		can_data_t data;
	} can_frame_t;

	typedef enum logic [2:0]
	{
		ERR_NONE,
		ERR_STUFF,  // Sixth equal bit in a stuffed field
		ERR_FORM,   // Fixed-form bit with wrong level
		ERR_ACK,    // Nobody acknowledged
		ERR_CRC     // Received CRC differs from computed one
	} can_error_e;

	// Frame FSM states, in bus order
	typedef enum logic [4:0]
	{
		ST_IDLE,
		ST_ID_A,
		ST_SRR_RTR,       // RTR in base frames, SRR in extended ones
		ST_IDE,
		ST_ID_B,
		ST_RTR,
		ST_RESERVED1,
		ST_RESERVED0,
		ST_DLC,
		ST_DATA,
		ST_CRC,
		ST_CRC_DELIMITER,
		ST_ACK_SLOT,
		ST_ACK_DELIMITER,
		ST_EOF,
		ST_INTERMISSION,
		ST_ERROR_WAIT     // Waits for the bus to go idle
	} can_state_e;

endpackage

// File: src/can_bit_destuffer.sv
`timescale 1ns/10ps

module can_bit_destuffer
(
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	input  logic stuff_enable,  // High inside the stuffed part of the frame
	output logic stuff_bit,     // Current sample is a stuff bit
	output logic stuff_error    // Current sample extends a run past five
);

	import can_pkg::*;

	// Alternating start value so no run is seen right after reset
	localparam logic [STUFF_RUN-1:0] HISTORY_INIT = STUFF_RUN'(32'h5555_5555);

	logic [STUFF_RUN-1:0] history; // Newest bit in bit 0
	logic                 run_low;
	logic                 run_high;
	logic                 check;

	assign run_low = (history == '0);
	assign run_high = (history == '1);
	assign check = sample_point & stuff_enable;

	// Opposite level after a run, so the transmitter inserted it
	assign stuff_bit = check & ((run_low & rx_bit) | (run_high & ~rx_bit));

	// Same level again, six in a row
	assign stuff_error = check & ((run_low & ~rx_bit) | (run_high & rx_bit));

	// History follows every sample, stuff bits included
	// A stuff bit then starts the next run, as on the bus
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			history <= HISTORY_INIT;
		end
		else if (sample_point)
		begin
			history <= {history[STUFF_RUN-2:0], rx_bit};
		end
	end

endmodule

// File: src/can_crc15.sv
`timescale 1ns/10ps

module can_crc15
(
	input  logic               clock,
	input  logic               reset,
	input  logic               sample_point,
	input  logic               data_bit,
	input  logic               crc_clear,   // Start of frame
	input  logic               crc_enable,  // Inside the CRC-covered fields
	input  logic               stuff_bit,   // Stuff bits stay out of the CRC
	output can_pkg::can_crc_t  crc_value
);

	import can_pkg::*;

	logic feedback;
	logic shift;

	assign feedback = data_bit ^ crc_value[CRC_BITS-1];
	assign shift = sample_point & crc_enable & ~stuff_bit;

	//======================================================================
	// Serial CRC-15, one destuffed bit per sample
	//======================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			crc_value <= '0;
		end
		else if (crc_clear)
		begin
			crc_value <= '0;  // SOF is dominant, so starting from zero covers it
		end
		else if (shift)
		begin
			if (feedback)
				crc_value <= {crc_value[CRC_BITS-2:0], 1'b0} ^ CRC15_POLY;
			else
				crc_value <= {crc_value[CRC_BITS-2:0], 1'b0};
		end
	end

endmodule

// File: src/can_frame_fsm.sv
`timescale 1ns/10ps

module can_frame_fsm
#(
	parameter int unsigned INTERMISSION_BITS = 3  // 2 accepts SOF in the third bit
)
(
	input  logic                clock,
	input  logic                reset,
	input  logic                rx_bit,
	input  logic                sample_point,
	input  logic                stuff_bit,
	input  logic                stuff_error,
	input  can_pkg::can_crc_t   crc_value,
	output logic                stuff_enable,
	output logic                crc_clear,
	output logic                crc_enable,
	output can_pkg::can_frame_t frame,
	output logic                frame_valid,
	output can_pkg::can_error_e error,
	output logic                error_valid
);

	import can_pkg::*;

	can_state_e  state;
	can_state_e  next_state;
	logic [6:0]  bit_count;     // Bits taken in the current state
	logic        count_clear;   // Dominant bit breaks the idle run
	logic        take;          // Sample that carries a frame bit
	logic        sof;
	logic        frame_done;
	logic        detect_error;
	can_error_e  detect_code;

	// Field registers
	can_id_t     id_reg;
	logic        ide_reg;
	logic        rtr_reg;
	can_dlc_t    dlc_reg;
	can_data_t   data_reg;
	can_crc_t    crc_rx;

	can_dlc_t    dlc_shift;
	can_dlc_t    dlc_next;
	logic        dlc_last;
	logic [6:0]  data_last;     // Index of the last data bit

	assign take = sample_point & ~stuff_bit;
	assign sof = sample_point & (state == ST_IDLE) & ~rx_bit;
	assign crc_clear = sof;

	// Stuffing runs SOF to CRC; the CRC delimiter can still see a stuff bit
	assign stuff_enable = (state >= ST_ID_A) && (state <= ST_CRC_DELIMITER);
	assign crc_enable = (state >= ST_ID_A) && (state <= ST_DATA);

	// DLC above 8 means 8 bytes
	assign dlc_shift = {dlc_reg[DLC_BITS-2:0], rx_bit};
	assign dlc_last = (bit_count == 7'(DLC_BITS - 1));
	assign dlc_next = (dlc_last && dlc_shift > can_dlc_t'(MAX_DATA_BYTES))
		? can_dlc_t'(MAX_DATA_BYTES) : dlc_shift;
	assign data_last = {dlc_reg, 3'b000} - 7'd1;

	//======================================================================
	// Next state and checks
	//======================================================================

	always_comb
	begin
		next_state = state;
		count_clear = 1'b0;
		frame_done = 1'b0;
		detect_error = 1'b0;
		detect_code = ERR_NONE;
		if (stuff_error)
		begin
			detect_error = 1'b1;
			detect_code = ERR_STUFF;
		end
		else if (take)
		begin
			unique case (state)
				ST_IDLE:
					if (!rx_bit)
						next_state = ST_ID_A;  // SOF
				ST_ID_A:
					if (bit_count == 7'(ID_A_BITS - 1))
						next_state = ST_SRR_RTR;
				ST_SRR_RTR:
					next_state = ST_IDE;
				ST_IDE:
					next_state = rx_bit ? ST_ID_B : ST_RESERVED0;  // Base skips r1
				ST_ID_B:
					if (bit_count == 7'(ID_B_BITS - 1))
						next_state = ST_RTR;
				ST_RTR:
					next_state = ST_RESERVED1;
				ST_RESERVED1:
					next_state = ST_RESERVED0;
				ST_RESERVED0:
					next_state = ST_DLC;
				ST_DLC:
					if (dlc_last)
						next_state = (rtr_reg || dlc_next == '0) ? ST_CRC : ST_DATA;
				ST_DATA:
					if (bit_count == data_last)
						next_state = ST_CRC;
				ST_CRC:
					if (bit_count == 7'(CRC_BITS - 1))
						next_state = ST_CRC_DELIMITER;
				ST_CRC_DELIMITER:
					if (!rx_bit)
					begin
						detect_error = 1'b1;
						detect_code = ERR_FORM;
					end
					else
						next_state = ST_ACK_SLOT;
				ST_ACK_SLOT:
					if (rx_bit)
					begin
						detect_error = 1'b1;
						detect_code = ERR_ACK;  // No receiver drove the slot
					end
					else
						next_state = ST_ACK_DELIMITER;
				ST_ACK_DELIMITER:
					if (crc_rx != crc_value)
					begin
						detect_error = 1'b1;
						detect_code = ERR_CRC;
					end
					else if (!rx_bit)
					begin
						detect_error = 1'b1;
						detect_code = ERR_FORM;
					end
					else
						next_state = ST_EOF;
				ST_EOF:
					if (!rx_bit)
					begin
						detect_error = 1'b1;
						detect_code = ERR_FORM;
					end
					else if (bit_count == 7'(EOF_BITS - 1))
					begin
						frame_done = 1'b1;
						next_state = ST_INTERMISSION;
					end
				ST_INTERMISSION:
					if (!rx_bit)
					begin
						detect_error = 1'b1;
						detect_code = ERR_FORM;
					end
					else if (bit_count == 7'(INTERMISSION_BITS - 1))
						next_state = ST_IDLE;  // SOF may follow at once
				ST_ERROR_WAIT:
					if (!rx_bit)
						count_clear = 1'b1;  // Restart the recessive run
					else if (bit_count == 7'(IDLE_RECOVERY_BITS - 1))
						next_state = ST_IDLE;
				default:
					next_state = ST_IDLE;
			endcase
		end
		if (detect_error)
			next_state = ST_ERROR_WAIT;
	end

	//======================================================================
	// Control registers
	//======================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			bit_count <= '0;
			frame_valid <= 1'b0;
			error <= ERR_NONE;
			error_valid <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (next_state != state || count_clear)
				bit_count <= '0;  // Each field counts from zero
			else if (take && state != ST_IDLE)
				bit_count <= bit_count + 7'd1;
			frame_valid <= frame_done;  // One clock after the last EOF sample
			error_valid <= detect_error;
			if (detect_error)
				error <= detect_code;  // Holds until the next error
		end
	end

	//======================================================================
	// Field capture
	//======================================================================

	always_ff @(posedge clock)
	begin
		if (sof)
		begin
			id_reg <= '0;    // Base ids end up right-aligned
			data_reg <= '0;  // Unused bytes read as zero
		end
		else if (take)
		begin
			unique case (state)
				ST_ID_A, ST_ID_B:
					id_reg <= {id_reg[$bits(can_id_t)-2:0], rx_bit};
				ST_SRR_RTR, ST_RTR:
					rtr_reg <= rx_bit;  // Extended frames overwrite the SRR value
				ST_IDE:
					ide_reg <= rx_bit;
				ST_DLC:
					dlc_reg <= dlc_next;
				ST_DATA:
					data_reg <= {data_reg[$bits(can_data_t)-2:0], rx_bit};
				ST_CRC:
					crc_rx <= {crc_rx[CRC_BITS-2:0], rx_bit};
				default:
					;  // Reserved bits and fixed-form bits are only checked
			endcase
		end
		if (frame_done)
		begin
			frame <= '{ide: ide_reg, rtr: rtr_reg, id: id_reg, dlc: dlc_reg,
				data: data_reg};
		end
	end

endmodule

// File: src/can_decoder.sv
`timescale 1ns/10ps

module can_decoder
#(
	parameter int unsigned INTERMISSION_BITS = 3
)
(
	input  logic                clock,
	input  logic                reset,
	input  logic                rx_bit,        // Bus level after the transceiver
	input  logic                sample_point,  // One clock per bit time
	output can_pkg::can_frame_t frame,
	output logic                frame_valid,
	output can_pkg::can_error_e error,
	output logic                error_valid
);

	import can_pkg::*;

	//======================================================================
	// Destuffer and CRC feeding the frame FSM
	//======================================================================

	logic     stuff_bit;
	logic     stuff_error;
	logic     stuff_enable;
	logic     crc_clear;
	logic     crc_enable;
	can_crc_t crc_value;

	can_bit_destuffer can_bit_destuffer_i
	(
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_enable (stuff_enable),
		.stuff_bit    (stuff_bit),
		.stuff_error  (stuff_error)
	);

	can_crc15 can_crc15_i
	(
		.clock        (clock),
		.reset        (reset),
		.sample_point (sample_point),
		.data_bit     (rx_bit),
		.crc_clear    (crc_clear),
		.crc_enable   (crc_enable),
		.stuff_bit    (stuff_bit),
		.crc_value    (crc_value)
	);

	can_frame_fsm #(.INTERMISSION_BITS(INTERMISSION_BITS)) can_frame_fsm_i
	(
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_bit    (stuff_bit),
		.stuff_error  (stuff_error),
		.crc_value    (crc_value),
		.stuff_enable (stuff_enable),
		.crc_clear    (crc_clear),
		.crc_enable   (crc_enable),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.error        (error),
		.error_valid  (error_valid)
	);

endmodule

// File: tests/can_frame_model.svh
`ifndef CAN_FRAME_MODEL_SVH
`define CAN_FRAME_MODEL_SVH

	//======================================================================
	// Transmitter-side reference model
	//======================================================================

	logic [31:0] lfsr_state = 32'h2ca4;  // x^32 + x^22 + x^2 + x + 1
	logic        raw_bits[$];            // SOF through CRC, unstuffed
	logic        stream_bits[$];         // Bus order, stuffed, with trailer

	// One LFSR step per random bit
	function automatic logic next_random_bit();
		logic feedback;
		feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], feedback};
		return feedback;
	endfunction

	function automatic logic [63:0] random_value(int unsigned width);
		logic [63:0] value;
		int unsigned i;
		value = '0;
		for (i = 0; i < width; i++)
			value = {value[62:0], next_random_bit()};  // Right-aligned
		return value;
	endfunction

	// Generator x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	function automatic can_crc_t crc_of_raw();
		can_crc_t crc;
		logic     top;
		int       i;
		crc = '0;
		for (i = 0; i < raw_bits.size(); i++)
		begin
			top = raw_bits[i] ^ crc[14];
			crc = {crc[13:0], 1'b0};
			if (top)
				crc = crc ^ 15'h4599;
		end
		return crc;
	endfunction

	// Remote frames carry no data, DLC above 8 still means 8 bytes
	function automatic int unsigned data_bytes(logic rtr, can_dlc_t dlc);
		if (rtr)
			return 0;
		return (dlc > 4'd8) ? 8 : int'(dlc);
	endfunction

	// Arbitration, control, data and CRC fields; flip_crc < 0 keeps the CRC
	function automatic void build_raw(logic ide, logic rtr, can_id_t id, can_dlc_t dlc,
		can_data_t data, int flip_crc);
		can_crc_t crc;
		int       i;
		raw_bits.delete();
		raw_bits.push_back(1'b0);  // SOF
		if (ide)
		begin
			for (i = 28; i >= 18; i--)
				raw_bits.push_back(id[i]);  // Base part first
			raw_bits.push_back(1'b1);       // SRR
			raw_bits.push_back(1'b1);       // IDE
			for (i = 17; i >= 0; i--)
				raw_bits.push_back(id[i]);
			raw_bits.push_back(rtr);
			raw_bits.push_back(1'b0);       // r1
		end
		else
		begin
			for (i = 10; i >= 0; i--)
				raw_bits.push_back(id[i]);
			raw_bits.push_back(rtr);
			raw_bits.push_back(1'b0);       // IDE
		end
		raw_bits.push_back(1'b0);           // r0
		for (i = 3; i >= 0; i--)
			raw_bits.push_back(dlc[i]);     // Raw DLC, even above 8
		for (i = 8 * data_bytes(rtr, dlc) - 1; i >= 0; i--)
			raw_bits.push_back(data[i]);    // First byte is the top used byte
		crc = crc_of_raw();
		if (flip_crc >= 0)
			crc[flip_crc] = ~crc[flip_crc];
		for (i = 14; i >= 0; i--)
			raw_bits.push_back(crc[i]);
	endfunction

	// Complement after five equal bits; drop_first leaves out the first one
	function automatic void stuff_raw(logic drop_first);
		logic        last;
		int unsigned run;
		logic        dropped;
		int          i;
		stream_bits.delete();
		last = 1'b1;  // Idle bus before SOF
		run = 0;
		dropped = 1'b0;
		for (i = 0; i < raw_bits.size(); i++)
		begin
			stream_bits.push_back(raw_bits[i]);
			run = (raw_bits[i] == last) ? run + 1 : 1;
			last = raw_bits[i];
			if (run == 5 && drop_first && !dropped)
				dropped = 1'b1;  // Six equal bits follow on the bus
			else if (run == 5)
			begin
				stream_bits.push_back(~last);
				last = ~last;
				run = 1;
			end
		end
	endfunction

	function automatic void append_trailer(logic crc_delimiter, logic ack_slot);
		int i;
		stream_bits.push_back(crc_delimiter);
		stream_bits.push_back(ack_slot);
		stream_bits.push_back(1'b1);  // ACK delimiter
		for (i = 0; i < 7; i++)
			stream_bits.push_back(1'b1);  // EOF
	endfunction

	function automatic can_frame_t expected_frame(logic ide, logic rtr, can_id_t id,
		can_dlc_t dlc, can_data_t data);
		can_frame_t f;
		f.ide = ide;
		f.rtr = rtr;
		f.id = ide ? id : (id & 29'h7ff);
		f.dlc = (dlc > 4'd8) ? 4'd8 : dlc;
		f.data = rtr ? '0 : data;
		return f;
	endfunction

`endif

// File: tests/tb_can_decoder.sv
`timescale 1ns/10ps

module tb_can_decoder;

	import can_pkg::*;

	localparam int unsigned CLOCK_NS = 4;
	localparam int unsigned CLOCKS_PER_BIT = 4;
	localparam int unsigned GAP_BITS = 14;      // Idle after each stream
	localparam int unsigned LEAD_BITS = 12;     // Idle after reset
	localparam int unsigned MARGIN_CLOCKS = 8;

	logic        clock;
	logic        reset;
	logic        rx_bit;
	logic        sample_point;
	can_frame_t  frame;
	logic        frame_valid;
	can_error_e  error;
	logic        error_valid;

	`include "can_frame_model.svh"

	// Planned tests, one entry each
	string       test_name[$];
	logic        test_is_frame[$];
	can_frame_t  test_frame[$];
	can_error_e  test_error[$];
	int unsigned test_len[$];     // Bits incl. idle gap
	logic        stim_bits[$];    // All streams back to back

	logic        plan_ready = 1'b0;
	int unsigned streams_started = 0;
	int unsigned checks_done = 0;
	int unsigned pass_count = 0;
	int unsigned fail_count = 0;
	int unsigned pulse_count = 0;

	can_decoder #(.INTERMISSION_BITS(3)) can_decoder_i
	(
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.error        (error),
		.error_valid  (error_valid)
	);

	always
	begin
		clock = 1'b0;
		#(CLOCK_NS / 2);
		clock = 1'b1;
		#(CLOCK_NS / 2);
	end

	//======================================================================
	// Test plan
	//======================================================================

	function automatic void queue_test(string name, logic is_frame, can_frame_t exp_frame,
		can_error_e exp_error);
		int i;
		for (i = 0; i < stream_bits.size(); i++)
			stim_bits.push_back(stream_bits[i]);
		for (i = 0; i < GAP_BITS; i++)
			stim_bits.push_back(1'b1);
		test_name.push_back(name);
		test_is_frame.push_back(is_frame);
		test_frame.push_back(exp_frame);
		test_error.push_back(exp_error);
		test_len.push_back(stream_bits.size() + GAP_BITS);
	endfunction

	function automatic void plan_frame(string name, logic ide, logic rtr, can_id_t id,
		can_dlc_t dlc, can_data_t data);
		build_raw(ide, rtr, id, dlc, data, -1);
		stuff_raw(1'b0);
		append_trailer(1'b1, 1'b0);
		queue_test(name, 1'b1, expected_frame(ide, rtr, id, dlc, data), ERR_NONE);
	endfunction

	function automatic void plan_tests();
		int unsigned d;
		can_id_t     id;
		can_dlc_t    dlc;
		can_data_t   data;
		for (d = 0; d <= 8; d++)
		begin
			id = can_id_t'(random_value(ID_A_BITS));
			data = random_value(8 * d);
			plan_frame($sformatf("base_dlc%0d", d), 1'b0, 1'b0, id, can_dlc_t'(d), data);
		end
		for (d = 0; d < 6; d++)
		begin
			id = can_id_t'(random_value(29));
			dlc = can_dlc_t'(random_value(4) % 9);
			data = random_value(8 * dlc);
			plan_frame($sformatf("ext_data%0d", d), 1'b1, 1'b0, id, dlc, data);
		end
		for (d = 0; d < 4; d++)
		begin
			id = can_id_t'(random_value(d[0] ? 29 : 11));
			dlc = can_dlc_t'(random_value(3) + 1);  // Non-zero DLC, no data
			plan_frame($sformatf("remote%0d", d), d[0], 1'b1, id, dlc, '0);
		end
		// One CRC bit flipped before stuffing
		id = can_id_t'(random_value(11));
		dlc = can_dlc_t'(random_value(3) + 1);
		build_raw(1'b0, 1'b0, id, dlc, random_value(8 * dlc), int'(random_value(4) % 15));
		stuff_raw(1'b0);
		append_trailer(1'b1, 1'b0);
		queue_test("crc_error", 1'b0, '0, ERR_CRC);
		id = can_id_t'(random_value(11));
		plan_frame("after_crc_error", 1'b0, 1'b0, id, 4'd2, random_value(16));
		// All-zero id, first stuff bit missing
		build_raw(1'b0, 1'b0, '0, 4'd1, random_value(8), -1);
		stuff_raw(1'b1);
		append_trailer(1'b1, 1'b0);
		queue_test("stuff_error", 1'b0, '0, ERR_STUFF);
		build_raw(1'b1, 1'b0, can_id_t'(random_value(29)), 4'd3, random_value(24), -1);
		stuff_raw(1'b0);
		append_trailer(1'b1, 1'b1);  // Nobody acks
		queue_test("ack_error", 1'b0, '0, ERR_ACK);
		build_raw(1'b0, 1'b0, can_id_t'(random_value(11)), 4'd4, random_value(32), -1);
		stuff_raw(1'b0);
		append_trailer(1'b0, 1'b0);  // Dominant CRC delimiter
		queue_test("form_error", 1'b0, '0, ERR_FORM);
		for (d = 9; d <= 15; d++)
		begin
			id = can_id_t'(random_value(d[0] ? 29 : 11));
			plan_frame($sformatf("dlc%0d_capped", d), d[0], 1'b0, id, can_dlc_t'(d),
				random_value(64));
		end
	endfunction

	//======================================================================
	// Driver and compare tasks
	//======================================================================

	// One bit time, strobe on its first clock
	task automatic send_bit(logic value);
		@(posedge clock);
		#1;
		rx_bit = value;
		sample_point = 1'b1;
		@(posedge clock);
		#1;
		sample_point = 1'b0;
		repeat (CLOCKS_PER_BIT - 2) @(posedge clock);
	endtask

	// Field dump for FAIL lines
	function automatic string frame_text(can_frame_t f);
		return $sformatf("ide=%0b rtr=%0b id=%h dlc=%0d data=%h",
			f.ide, f.rtr, f.id, f.dlc, f.data);
	endfunction

	task automatic check_frame(string name, can_frame_t expected, can_frame_t actual);
		if (actual === expected)
		begin
			pass_count++;
			$display("PASS %s", name);
		end
		else
		begin
			fail_count++;
			$display("FAIL %s expected %s actual %s", name,
				frame_text(expected), frame_text(actual));
		end
	endtask

	task automatic check_error(string name, can_error_e expected, can_error_e actual);
		if (actual === expected)
		begin
			pass_count++;
			$display("PASS %s", name);
		end
		else
		begin
			fail_count++;
			$display("FAIL %s expected %s actual %s", name, expected.name(), actual.name());
		end
	endtask

	//======================================================================
	// Processes
	//======================================================================

	initial
	begin : stimulus
		int unsigned t;
		int unsigned k;
		int unsigned pos;
		reset = 1'b1;
		rx_bit = 1'b1;  // Recessive idle
		sample_point = 1'b0;
		plan_tests();
		plan_ready = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (LEAD_BITS) send_bit(1'b1);
		pos = 0;
		for (t = 0; t < test_name.size(); t++)
		begin
			streams_started = t + 1;
			for (k = 0; k < test_len[t]; k++)
			begin
				send_bit(stim_bits[pos]);
				pos++;
			end
		end
		wait (checks_done == test_name.size());
		if (pulse_count != test_name.size())
		begin
			fail_count++;
			$display("saw %0d result pulses for %0d streams", pulse_count, test_name.size());
		end
		$display("summary: %0d tests, %0d passed, %0d failed", test_name.size(), pass_count,
			fail_count);
		if (fail_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Waits for the pulse of each stream and checks it
	initial
	begin : compare
		int unsigned t;
		int unsigned waited;
		int unsigned limit;
		logic        seen;
		wait (plan_ready);
		for (t = 0; t < test_name.size(); t++)
		begin
			wait (streams_started > t);
			limit = test_len[t] * CLOCKS_PER_BIT + MARGIN_CLOCKS;
			waited = 0;
			seen = 1'b0;
			while (!seen && waited < limit)
			begin
				@(negedge clock);  // Outputs settled
				waited++;
				seen = frame_valid | error_valid;
			end
			if (!seen)
			begin
				fail_count++;
				$display("%s: no frame_valid or error_valid within %0d clocks", test_name[t],
					limit);
			end
			else if (test_is_frame[t] && frame_valid)
				check_frame(test_name[t], test_frame[t], frame);
			else if (test_is_frame[t])
			begin
				fail_count++;
				$display("%s: expected a frame, error_valid came with %s", test_name[t],
					error.name());
			end
			else if (error_valid)
				check_error(test_name[t], test_error[t], error);
			else
			begin
				fail_count++;
				$display("%s: expected %s, frame_valid came instead", test_name[t],
					test_error[t].name());
			end
			checks_done++;
		end
	end

	// Counts every result pulse, stray ones too
	always @(negedge clock)
	begin
		if (frame_valid === 1'b1)
			pulse_count++;
		if (error_valid === 1'b1)
			pulse_count++;
	end

	initial
	begin : watchdog
		int unsigned limit_ns;
		wait (plan_ready);
		limit_ns = ((stim_bits.size() + LEAD_BITS) * CLOCKS_PER_BIT + 16 + 200) * CLOCK_NS;
		#(limit_ns);
		$display("watchdog: run still busy after %0d ns", limit_ns);
		$display("tests failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+tests
src/can_pkg.sv
src/can_bit_destuffer.sv
src/can_crc15.sv
src/can_frame_fsm.sv
src/can_decoder.sv
tests/tb_can_decoder.sv

// File: Bender.yml
package:
  name: can_decoder

sources:
  - src/can_pkg.sv
  - src/can_bit_destuffer.sv
  - src/can_crc15.sv
  - src/can_frame_fsm.sv
  - src/can_decoder.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_can_decoder.sv
